// ==== tb.f ====
source/icache_pkg.sv
source/icache_way_sram.sv
source/icache_tag_array.sv
source/icache_ctrl.sv
source/line_memory.sv
source/icache_top.sv
sim/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f tb.f --top-module icache_tb

# program.hex is read relative to the project root
out=$(./obj_dir/Vicache_tb 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Simulation PASSED"

// ==== program.hex ====
// one 128-bit line per row, line 0 first; word 3 at left, word 0 at right
000CFFF30008FFF70004FFFB0000FFFF
001CFFE30018FFE70014FFEB0010FFEF
002CFFD30028FFD70024FFDB0020FFDF
003CFFC30038FFC70034FFCB0030FFCF
004CFFB30048FFB70044FFBB0040FFBF
005CFFA30058FFA70054FFAB0050FFAF
006CFF930068FF970064FF9B0060FF9F
007CFF830078FF870074FF8B0070FF8F
008CFF730088FF770084FF7B0080FF7F
009CFF630098FF670094FF6B0090FF6F
00ACFF5300A8FF5700A4FF5B00A0FF5F
00BCFF4300B8FF4700B4FF4B00B0FF4F
00CCFF3300C8FF3700C4FF3B00C0FF3F
00DCFF2300D8FF2700D4FF2B00D0FF2F
00ECFF1300E8FF1700E4FF1B00E0FF1F
00FCFF0300F8FF0700F4FF0B00F0FF0F
010CFEF30108FEF70104FEFB0100FEFF
011CFEE30118FEE70114FEEB0110FEEF
012CFED30128FED70124FEDB0120FEDF
013CFEC30138FEC70134FECB0130FECF
014CFEB30148FEB70144FEBB0140FEBF
015CFEA30158FEA70154FEAB0150FEAF
016CFE930168FE970164FE9B0160FE9F
017CFE830178FE870174FE8B0170FE8F
018CFE730188FE770184FE7B0180FE7F
019CFE630198FE670194FE6B0190FE6F
01ACFE5301A8FE5701A4FE5B01A0FE5F
01BCFE4301B8FE4701B4FE4B01B0FE4F
01CCFE3301C8FE3701C4FE3B01C0FE3F
01DCFE2301D8FE2701D4FE2B01D0FE2F
01ECFE1301E8FE1701E4FE1B01E0FE1F
01FCFE0301F8FE0701F4FE0B01F0FE0F
020CFDF30208FDF70204FDFB0200FDFF
021CFDE30218FDE70214FDEB0210FDEF
022CFDD30228FDD70224FDDB0220FDDF
023CFDC30238FDC70234FDCB0230FDCF
024CFDB30248FDB70244FDBB0240FDBF
025CFDA30258FDA70254FDAB0250FDAF
026CFD930268FD970264FD9B0260FD9F
027CFD830278FD870274FD8B0270FD8F
028CFD730288FD770284FD7B0280FD7F
029CFD630298FD670294FD6B0290FD6F
02ACFD5302A8FD5702A4FD5B02A0FD5F
02BCFD4302B8FD4702B4FD4B02B0FD4F
02CCFD3302C8FD3702C4FD3B02C0FD3F
02DCFD2302D8FD2702D4FD2B02D0FD2F
02ECFD1302E8FD1702E4FD1B02E0FD1F
02FCFD0302F8FD0702F4FD0B02F0FD0F
030CFCF30308FCF70304FCFB0300FCFF
031CFCE30318FCE70314FCEB0310FCEF
032CFCD30328FCD70324FCDB0320FCDF
033CFCC30338FCC70334FCCB0330FCCF
034CFCB30348FCB70344FCBB0340FCBF
035CFCA30358FCA70354FCAB0350FCAF
036CFC930368FC970364FC9B0360FC9F
037CFC830378FC870374FC8B0370FC8F
038CFC730388FC770384FC7B0380FC7F
039CFC630398FC670394FC6B0390FC6F
03ACFC5303A8FC5703A4FC5B03A0FC5F
03BCFC4303B8FC4703B4FC4B03B0FC4F
03CCFC3303C8FC3703C4FC3B03C0FC3F
03DCFC2303D8FC2703D4FC2B03D0FC2F
03ECFC1303E8FC1703E4FC1B03E0FC1F
03FCFC0303F8FC0703F4FC0B03F0FC0F

// ==== sim/icache_tb.sv ====
module icache_tb;
	import icache_pkg::*;

	// request counts per test
	localparam int N_SEQ = 64;
	localparam int N_HIT = 2;
	localparam int N_RAND = 300;
	localparam int N_CREDIT = 200;
	localparam int N_FLUSH = 300;
	localparam int N_LIMIT = OUT_CREDITS;
	localparam int TOTAL_REQS = N_SEQ + N_HIT + N_RAND + N_CREDIT + N_FLUSH + N_LIMIT;
	localparam int TIMEOUT_CYCLES = TOTAL_REQS * (MEM_LATENCY + 6) + 200;
	localparam logic [ADDR_W-1:0] COLD_PC = 32'h0000_03A8; // line 58, untouched before

	logic clk;
	logic rst;
	fetch_req_t fetch;
	logic flush;
	logic credit_return;
	logic fetch_ready;
	inst_resp_t resp;

	logic [LINE_W-1:0] prog [MEM_LINES]; // copy of the backing memory image
	integer seed = 15674;
	integer side_seed = 15674 + 1; // consumer and flush driver draw from their own stream
	string test_name = "reset";
	logic [ADDR_W-1:0] last_pc = '0;
	bit withhold = 1'b0;
	bit hold_all = 1'b0; // consumer returns nothing
	bit flush_en = 1'b0;
	int sent_count = 0;

	// scoreboard, owned by the monitor
	logic [ADDR_W-1:0] pc_q [$];
	int cyc_q [$]; // acceptance edge per entry
	int cycle = 0;
	int accepted_count = 0;
	int resp_count = 0;
	int last_latency = 0;
	int returned_count = 0; // owned by the consumer

	icache_top i_icache_top (
		.clk,
		.rst,
		.fetch,
		.flush,
		.credit_return,
		.fetch_ready,
		.resp
	);

	// word at line pc[9:4], slot pc[3:2] of the program image
	function automatic logic [INST_W-1:0] expected_inst(input logic [ADDR_W-1:0] pc);
		logic [LINE_W-1:0] line;
		int word;
		line = prog[pc[9:4]];
		word = int'(pc[3:2]);
		return line[word*INST_W +: INST_W];
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at cycle %0d", cycle);
	endtask

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("MISMATCH %s %s expected 0x%0h actual 0x%0h",
				test_name, name, expected, actual));
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// compare process, sampled on the rising edge before any register moves
	always @(posedge clk) begin
		if (!rst) begin
			if (resp.valid) begin
				if (pc_q.size() == 0) begin
					fail_run($sformatf("response for pc 0x%0h arrived with no request pending",
						resp.pc));
				end else begin
					check("resp pc", pc_q[0], resp.pc);
					check("resp inst", expected_inst(pc_q[0]), resp.inst);
					last_latency = cycle - cyc_q[0];
					void'(pc_q.pop_front());
					void'(cyc_q.pop_front());
					resp_count++;
					check("responses held within credits", 32'd1,
						32'(resp_count - returned_count <= OUT_CREDITS));
				end
			end
			// anything left is in lookup or an owed miss, so it is squashed
			if (flush) begin
				pc_q.delete();
				cyc_q.delete();
			end
			if (fetch.valid && fetch_ready) begin
				pc_q.push_back(fetch.pc);
				cyc_q.push_back(cycle + 1);
				accepted_count++;
			end
		end
		cycle++;
		if (cycle > TIMEOUT_CYCLES) begin
			fail_run($sformatf("run exceeded the limit of %0d cycles", TIMEOUT_CYCLES));
		end
	end

	// credit consumer and flush driver
	initial begin
		int stall;
		flush = 1'b0;
		credit_return = 1'b0;
		stall = 0;
		forever begin
			@(negedge clk);
			credit_return = 1'b0;
			if (stall > 0) begin
				stall--;
			end else if (resp_count > returned_count && !hold_all) begin
				credit_return = 1'b1;
				returned_count++;
				if (withhold) begin
					stall = $random(side_seed) & 7; // hold back the next return
				end
			end
			flush = 1'b0;
			if (flush_en) begin
				flush = (($random(side_seed) & 7) == 0);
			end
		end
	end

	task automatic send_fetch(input logic [ADDR_W-1:0] pc);
		fetch.valid = 1'b1;
		fetch.pc = pc;
		while (!fetch_ready) begin
			@(negedge clk);
		end
		@(negedge clk); // taken on the edge in between
		fetch.valid = 1'b0;
		last_pc = pc;
		sent_count++;
	endtask

	// random pc in the 1 KiB window, or the next word when mixing
	task automatic pick_pc(input bit mix, output logic [ADDR_W-1:0] pc);
		integer rnd;
		rnd = $random(seed);
		if (mix && rnd[0]) begin
			pc = (last_pc + 32'd4) & 32'h0000_03FC;
		end else begin
			pc = {22'd0, rnd[11:4], 2'b00};
		end
	endtask

	task automatic start_test(input string name, input bit hold, input bit flushes);
		@(posedge clk);
		withhold = hold;
		flush_en = flushes;
		@(negedge clk);
		test_name = name;
	endtask

	task automatic wait_idle();
		while (pc_q.size() != 0 || resp_count != returned_count) begin
			@(negedge clk);
		end
	endtask

	task automatic wait_responses(input int target);
		while (resp_count < target) begin
			@(negedge clk);
		end
	endtask

	initial begin
		logic [ADDR_W-1:0] pc;
		int target;
		rst = 1'b1;
		fetch = '0;
		$readmemh("program.hex", prog);
		repeat (8) @(negedge clk);
		rst = 1'b0;

		start_test("cold_sequential", 1'b0, 1'b0);
		for (int i = 0; i < N_SEQ; i++) begin
			send_fetch(ADDR_W'(i * 4));
		end
		wait_idle();

		start_test("hit_latency", 1'b0, 1'b0);
		target = resp_count + 1;
		send_fetch(COLD_PC);
		wait_responses(target);
		send_fetch(COLD_PC); // same line right after the fill
		wait_responses(target + 1);
		check("refetch latency", 32'd1, last_latency);

		start_test("random_fetch", 1'b0, 1'b0);
		repeat (N_RAND) begin
			pick_pc(1'b0, pc);
			send_fetch(pc);
		end
		wait_idle();

		start_test("credit_backpressure", 1'b1, 1'b0);
		repeat (N_CREDIT) begin
			pick_pc(1'b1, pc);
			send_fetch(pc);
		end
		wait_idle();

		start_test("flush_stream", 1'b0, 1'b1);
		repeat (N_FLUSH) begin
			pick_pc(1'b1, pc);
			send_fetch(pc);
		end

		start_test("drain", 1'b0, 1'b0);
		wait_idle();

		// every credit must be back after the flushes, and none extra
		start_test("credit_limit", 1'b0, 1'b0);
		hold_all = 1'b1;
		target = resp_count + N_LIMIT;
		repeat (N_LIMIT) begin
			send_fetch(COLD_PC);
		end
		wait_responses(target);
		check("ready with no credits", 32'd0, 32'(fetch_ready));
		hold_all = 1'b0;
		wait_idle();

		check("requests accepted", sent_count, accepted_count);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== source/icache_top.sv ====
module icache_top (
	input  logic clk,
	input  logic rst,
	input  icache_pkg::fetch_req_t fetch,
	input  logic flush,
	input  logic credit_return,
	output logic fetch_ready,
	output icache_pkg::inst_resp_t resp
);
	import icache_pkg::*;

	logic [ADDR_W-1:0] lookup_pc;
	logic [WAYS-1:0] hit;
	logic [WAYS-1:0] way_en;
	logic way_we;
	logic [LINE_W-1:0] way_wdata;
	logic [INDEX_W-1:0] sram_index;
	logic [WAYS-1:0][LINE_W-1:0] way_rdata;
	fill_t fill;
	line_req_t mem_req;
	line_resp_t mem_resp;

	icache_ctrl i_icache_ctrl (
		.clk,
		.rst,
		.fetch,
		.flush,
		.credit_return,
		.hit,
		.way_rdata,
		.mem_resp,
		.fetch_ready,
		.resp,
		.lookup_pc,
		.way_en,
		.way_we,
		.way_wdata,
		.sram_index,
		.fill,
		.mem_req
	);

	icache_tag_array i_icache_tag_array (.clk, .rst, .lookup_pc, .fill, .hit);

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		icache_way_sram i_icache_way_sram (
			.clk,
			.en(way_en[w]),
			.we(way_we),
			.index(sram_index),
			.wdata(way_wdata),
			.rdata(way_rdata[w])
		);
	end

	line_memory i_line_memory (.clk, .rst, .req(mem_req), .resp(mem_resp));

endmodule

// ==== source/line_memory.sv ====
module line_memory (
	input  logic clk,
	input  logic rst,
	input  icache_pkg::line_req_t req,
	output icache_pkg::line_resp_t resp
);
	import icache_pkg::*;

	logic [LINE_W-1:0] mem [MEM_LINES];
	logic [MEM_LATENCY-1:0] pipe_valid;
	logic [LINE_ADDR_W-1:0] pipe_addr [MEM_LATENCY];

	initial begin
		$readmemh("program.hex", mem);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], req.valid};
		end
	end

	// address rides along with the valid bit
	always_ff @(posedge clk) begin
		pipe_addr[0] <= req.line_addr;
		for (int i = 1; i < MEM_LATENCY; i++) begin
			pipe_addr[i] <= pipe_addr[i-1];
		end
	end

	assign resp.valid = pipe_valid[MEM_LATENCY-1];
	assign resp.data = mem[pipe_addr[MEM_LATENCY-1]]; // read at last stage

	// controller keeps a single miss outstanding
	assert property (@(posedge clk) disable iff (rst) req.valid |-> (pipe_valid == '0));

endmodule

// ==== source/icache_ctrl.sv ====
module icache_ctrl (
	input  logic clk,
	input  logic rst,
	input  icache_pkg::fetch_req_t fetch,
	input  logic flush,
	input  logic credit_return,
	input  logic [icache_pkg::WAYS-1:0] hit,
	input  logic [icache_pkg::WAYS-1:0][icache_pkg::LINE_W-1:0] way_rdata,
	input  icache_pkg::line_resp_t mem_resp,
	output logic fetch_ready,
	output icache_pkg::inst_resp_t resp,
	output logic [icache_pkg::ADDR_W-1:0] lookup_pc,
	output logic [icache_pkg::WAYS-1:0] way_en,
	output logic way_we,
	output logic [icache_pkg::LINE_W-1:0] way_wdata,
	output logic [icache_pkg::INDEX_W-1:0] sram_index,
	output icache_pkg::fill_t fill,
	output icache_pkg::line_req_t mem_req
);
	import icache_pkg::*;

	miss_state_e state;
	logic lk_valid; // lookup stage
	logic [ADDR_W-1:0] lk_pc;
	logic lk_hit;
	logic out_valid; // output stage
	logic [ADDR_W-1:0] out_pc;
	logic [WAYS-1:0] out_hit;
	logic [LINE_W-1:0] out_line;
	logic miss_live; // response still owed for the miss
	logic [ADDR_W-1:0] miss_pc;
	logic [LINE_W-1:0] fill_line;
	logic [WAYS-1:0] victim;
	logic [CREDIT_W-1:0] credits;
	logic accept;
	logic squash_lk;
	logic squash_miss;
	logic miss_start;

	function automatic logic [INST_W-1:0] pick_word(
		input logic [LINE_W-1:0] line,
		input logic [ADDR_W-1:0] pc
	);
		return line[pc[OFFSET_W-1:2]*INST_W +: INST_W];
	endfunction

	assign lk_hit = |hit;
	assign fetch_ready = (state == MS_RUN) && (!lk_valid || lk_hit) && (credits != '0);
	assign accept = fetch.valid && fetch_ready;
	assign squash_lk = flush && lk_valid;
	assign squash_miss = flush && miss_live && (state == MS_REQ || state == MS_WAIT);
	assign miss_start = lk_valid && !lk_hit && !flush; // lk_valid only in MS_RUN

	always_ff @(posedge clk) begin
		if (rst) begin
			lk_valid <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			lk_valid <= accept; // a request taken during flush survives
			out_valid <= lk_valid && lk_hit && !flush;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			lk_pc <= fetch.pc;
		end
		out_pc <= lk_pc;
		out_hit <= hit;
		if (miss_start) begin
			miss_pc <= lk_pc;
		end
		if (state == MS_WAIT && mem_resp.valid) begin
			fill_line <= mem_resp.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= MS_RUN;
			miss_live <= 1'b0;
			victim <= WAYS'(1);
		end else begin
			case (state)
				MS_RUN: begin
					if (miss_start) begin
						state <= MS_REQ;
						miss_live <= 1'b1;
					end
				end
				MS_REQ: state <= MS_WAIT;
				MS_WAIT: begin
					if (mem_resp.valid) begin
						state <= MS_FILL;
					end
				end
				MS_FILL: begin
					state <= MS_RUN;
					miss_live <= 1'b0;
					victim <= {victim[WAYS-2:0], victim[WAYS-1]}; // rotate
				end
				default: state <= MS_RUN;
			endcase
			if (squash_miss) begin
				miss_live <= 1'b0; // line still gets filled
			end
		end
	end

	// one credit per accepted request, back on return or squash
	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_W'(OUT_CREDITS);
		end else begin
			credits <= credits + CREDIT_W'(credit_return)
				+ CREDIT_W'(squash_lk || squash_miss) - CREDIT_W'(accept);
		end
	end

	always_comb begin
		out_line = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (out_hit[w]) begin
				out_line = out_line | way_rdata[w];
			end
		end
	end

	// miss answer comes straight from the returned line
	always_comb begin
		if (state == MS_FILL) begin
			resp.valid = miss_live;
			resp.pc = miss_pc;
			resp.inst = pick_word(fill_line, miss_pc);
		end else begin
			resp.valid = out_valid;
			resp.pc = out_pc;
			resp.inst = pick_word(out_line, out_pc);
		end
	end

	always_comb begin
		fill.valid = (state == MS_FILL);
		fill.way = victim;
		fill.index = miss_pc[OFFSET_W +: INDEX_W];
		fill.tag = miss_pc[ADDR_W-1 -: TAG_W];
		mem_req.valid = (state == MS_REQ);
		mem_req.line_addr = miss_pc[OFFSET_W +: LINE_ADDR_W];
	end

	assign lookup_pc = lk_pc;
	assign way_we = (state == MS_FILL);
	assign way_wdata = fill_line;
	assign way_en = way_we ? victim : (lk_valid ? hit : '0);
	assign sram_index = way_we ? fill.index : lk_pc[OFFSET_W +: INDEX_W];

	assert property (@(posedge clk) disable iff (rst) credits <= CREDIT_W'(OUT_CREDITS));

	// the line comes back while the FSM still waits for it
	assert property (@(posedge clk) disable iff (rst)
		mem_req.valid |-> ##MEM_LATENCY (state == MS_WAIT && mem_resp.valid));

endmodule

// ==== source/icache_tag_array.sv ====
module icache_tag_array (
	input  logic clk,
	input  logic rst,
	input  logic [icache_pkg::ADDR_W-1:0] lookup_pc,
	input  icache_pkg::fill_t fill,
	output logic [icache_pkg::WAYS-1:0] hit
);
	import icache_pkg::*;

	logic [TAG_W-1:0] tags [WAYS][SETS];
	logic [SETS-1:0] valid_bits [WAYS];
	logic [INDEX_W-1:0] lookup_index;
	logic [TAG_W-1:0] lookup_tag;

	assign lookup_index = lookup_pc[OFFSET_W +: INDEX_W];
	assign lookup_tag = lookup_pc[ADDR_W-1 -: TAG_W];

	// all four ways compared in parallel
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hit[w] = valid_bits[w][lookup_index] && (tags[w][lookup_index] == lookup_tag);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < WAYS; w++) begin
				valid_bits[w] <= '0;
			end
		end else if (fill.valid) begin
			for (int w = 0; w < WAYS; w++) begin
				if (fill.way[w]) begin
					valid_bits[w][fill.index] <= 1'b1;
				end
			end
		end
	end

	// tag written with the valid bit, only for the named way
	always_ff @(posedge clk) begin
		if (fill.valid) begin
			for (int w = 0; w < WAYS; w++) begin
				if (fill.way[w]) begin
					tags[w][fill.index] <= fill.tag;
				end
			end
		end
	end

	// victim pointer from the controller must name a single way
	assert property (@(posedge clk) disable iff (rst)
		fill.valid |-> $onehot(fill.way));

	// a line lives in at most one way, fills only go in after a miss
	assert property (@(posedge clk) disable iff (rst) $onehot0(hit));

endmodule

// ==== source/icache_way_sram.sv ====
module icache_way_sram (
	input  logic clk,
	input  logic en,
	input  logic we,
	input  logic [icache_pkg::INDEX_W-1:0] index,
	input  logic [icache_pkg::LINE_W-1:0] wdata,
	output logic [icache_pkg::LINE_W-1:0] rdata
);
	import icache_pkg::*;

	logic [LINE_W-1:0] mem [SETS];

	// one port, so a write cycle leaves rdata alone
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				mem[index] <= wdata;
			end else begin
				rdata <= mem[index];
			end
		end
	end

	// an access needs a known set, whether read or fill
	assert property (@(posedge clk) (en || we) |-> !$isunknown(index));

endmodule

// ==== source/icache_pkg.sv ====
package icache_pkg;

	// address and data widths
	localparam int ADDR_W = 32;
	localparam int LINE_W = 128;
	localparam int INST_W = 32;

	// cache geometry
	localparam int WAYS = 4;
	localparam int SETS = 8;
	localparam int OFFSET_W = 4; // 16-byte line
	localparam int INDEX_W = 3;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W; // 25

	// backing memory
	localparam int MEM_LINES = 64;
	localparam int MEM_LATENCY = 3; // request to response, in cycles
	localparam int LINE_ADDR_W = $clog2(MEM_LINES);

	// flow control toward the consumer
	localparam int OUT_CREDITS = 2;
	localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] pc;
	} fetch_req_t;

	typedef struct packed {
		logic valid;
		logic [ADDR_W-1:0] pc;
		logic [INST_W-1:0] inst;
	} inst_resp_t;

	typedef struct packed {
		logic valid;
		logic [LINE_ADDR_W-1:0] line_addr;
	} line_req_t;

	typedef struct packed {
		logic valid;
		logic [LINE_W-1:0] data;
	} line_resp_t;

	// tag array write command, one way at a time
	typedef struct packed {
		logic valid;
		logic [WAYS-1:0] way; // one-hot
		logic [INDEX_W-1:0] index;
		logic [TAG_W-1:0] tag;
	} fill_t;

	typedef enum logic [1:0] {
		MS_RUN,  // lookups flowing
		MS_REQ,  // line request on the bus
		MS_WAIT, // waiting on backing memory
		MS_FILL  // write the line, answer the miss
	} miss_state_e;

endpackage
